//--- logic/isaPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I subset only. Encodings outside opcodeT decode as no-ops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isaPkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Register mirrored on the debug output
  localparam int DBG_REG = 10;

  // Instruction queue depth, which is also the credit count at reset
  localparam int QUEUE_DEPTH = 2;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  // Counter holding 0 to QUEUE_DEPTH
  localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1);

  // Instruction field positions
  localparam int OPCODE_LO = 0;
  localparam int OPCODE_HI = 6;
  localparam int RD_LO     = 7;
  localparam int FUNCT3_LO = 12;
  localparam int FUNCT3_HI = 14;
  localparam int RS1_LO    = 15;
  localparam int RS2_LO    = 20;
  localparam int FUNCT7_LO = 25;
  localparam int FUNCT7_HI = 31;

  // Major opcodes that the core executes
  typedef enum logic [6:0] {
    opcLui    = 7'b0110111,
    opcOpImm  = 7'b0010011,
    opcOp     = 7'b0110011,
    opcLoad   = 7'b0000011,
    opcStore  = 7'b0100011,
    opcBranch = 7'b1100011,
    opcJal    = 7'b1101111
  } opcodeT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor
  } aluOpT;

endpackage

//--- logic/memMapPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 128 KB RAM below 0x20000. I/O when address bits 17:16 are both set
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package memMapPkg;

  localparam int ADDR_W = 32;

  // Byte written here goes out on the UART
  localparam logic [ADDR_W-1:0] IO_UART_ADDR = 32'h0003_0000;
  // Any store here stops the program
  localparam logic [ADDR_W-1:0] IO_HALT_ADDR = 32'h0003_0004;

  // Address bits that mark the I/O region
  localparam int IO_SEL_HI = 17;
  localparam int IO_SEL_LO = 16;

  typedef enum logic {
    memRead,
    memWrite
  } memAccessT;

endpackage

//--- logic/memArbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte bus with one-cycle read return. Requests must hold until done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module memArbiter (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         rdy_in,
  input  logic [7:0]                   memDin,
  input  logic                         ioBufferFull,
  input  logic                         fetchReq,
  input  logic [memMapPkg::ADDR_W-1:0] fetchAddr,
  input  logic                         dataReq,
  input  memMapPkg::memAccessT         dataKind,
  input  logic [memMapPkg::ADDR_W-1:0] dataAddr,
  input  logic [7:0]                   dataWdata,
  output logic [7:0]                   memDout,
  output logic [memMapPkg::ADDR_W-1:0] memA,
  output logic                         memWr,
  output logic                         fetchDone,
  output logic [isaPkg::XLEN-1:0]      fetchWord,
  output logic                         dataDone,
  output logic [7:0]                   dataRdata
);
  import memMapPkg::*;

  typedef enum logic [1:0] {
    stIdle,
    stFetchBytes,
    stDataAccess
  } stateT;

  stateT       state;
  logic [2:0]  byteCnt;
  logic [23:0] lowBytes;
  logic        ioSel;
  logic        ioHold;
  logic        rdyLast;
  logic [7:0]  heldDin;
  logic [7:0]  busByte;

  assign ioSel  = dataAddr[IO_SEL_HI:IO_SEL_LO] == 2'b11;
  // UART write has to wait for room in the output buffer
  assign ioHold = (dataKind == memWrite) && ioSel && ioBufferFull;

  // RAM keeps reading during a stall, so the byte for the old address is kept
  always_ff @(posedge clk_in)
  begin
    rdyLast <= rdy_in;
    if (rdyLast)
      heldDin <= memDin;
  end

  // Byte for the address presented before the last advancing edge
  assign busByte = rdyLast ? memDin : heldDin;

  // Last fetch byte is taken straight from the bus
  assign fetchDone = (state == stFetchBytes) && (byteCnt == 3'd4);
  assign fetchWord = {busByte, lowBytes};

  // Write is done in its bus cycle, a read one cycle later
  assign dataDone  = (state == stDataAccess) &&
                     ((dataKind == memWrite) ? (byteCnt == 3'd0) : (byteCnt == 3'd1));
  assign dataRdata = memDin;

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      state   <= stIdle;
      byteCnt <= '0;
      memA    <= '0;
      memDout <= '0;
      memWr   <= 1'b0;
    end
    else if (rdy_in)
    begin
      case (state)
        stIdle:
        begin
          // Data side wins over a fetch that has not started
          if (dataReq)
          begin
            if (!ioHold)
            begin
              memA    <= dataAddr;
              memDout <= dataWdata;
              memWr   <= dataKind == memWrite;
              byteCnt <= '0;
              state   <= stDataAccess;
            end
          end
          else if (fetchReq)
          begin
            memA    <= fetchAddr;
            memWr   <= 1'b0;
            byteCnt <= '0;
            state   <= stFetchBytes;
          end
        end
        stFetchBytes:
        begin
          byteCnt <= byteCnt + 3'd1;
          // Bytes arrive one cycle behind their address
          if (byteCnt inside {[3'd1:3'd3]})
            lowBytes <= {busByte, lowBytes[23:8]};
          if (byteCnt < 3'd3)
            memA <= fetchAddr + ADDR_W'(byteCnt + 3'd1);
          if (fetchDone)
            state <= stIdle;
        end
        stDataAccess:
        begin
          memWr   <= 1'b0;
          byteCnt <= byteCnt + 3'd1;
          if (dataDone)
            state <= stIdle;
        end
        default:
          state <= stIdle;
      endcase
    end
  end

  // I/O write reaches the bus only from an edge where the buffer had room
  assert property (@(posedge clk_in) disable iff (rst_in)
    (memWr && !$past(memWr) && memA[IO_SEL_HI:IO_SEL_LO] == 2'b11)
      |-> !$past(ioBufferFull));

  assert property (@(posedge clk_in) disable iff (rst_in)
    !(fetchDone && dataDone));

endmodule

//--- logic/fetchUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One fetch in flight. A word may be sent only while a credit is held
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fetchUnit (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         rdy_in,
  input  logic                         fetchDone,
  input  logic [isaPkg::XLEN-1:0]      fetchWord,
  input  logic                         instrCredit,
  input  logic                         redirectValid,
  input  logic [memMapPkg::ADDR_W-1:0] redirectPc,
  output logic                         fetchReq,
  output logic [memMapPkg::ADDR_W-1:0] fetchAddr,
  output logic                         instrValid,
  output logic [isaPkg::XLEN-1:0]      instrWord,
  output logic [memMapPkg::ADDR_W-1:0] instrPc
);
  import isaPkg::*;
  import memMapPkg::*;

  logic [ADDR_W-1:0] pc;
  logic [CNT_W-1:0]  credits;
  logic [CNT_W-1:0]  creditsNext;
  logic              dropPending;
  logic              deliver;

  // Word fetched on a stale path is thrown away
  assign deliver     = fetchDone && !dropPending && !redirectValid;
  assign creditsNext = credits - CNT_W'(deliver) + CNT_W'(instrCredit);

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      pc          <= '0;
      credits     <= CNT_W'(QUEUE_DEPTH);
      fetchReq    <= 1'b0;
      dropPending <= 1'b0;
      instrValid  <= 1'b0;
    end
    else if (rdy_in)
    begin
      instrValid <= deliver;
      if (fetchDone)
      begin
        fetchReq    <= 1'b0;
        dropPending <= 1'b0;
      end
      if (redirectValid)
      begin
        // Queue was flushed, so every credit comes back
        pc      <= redirectPc;
        credits <= CNT_W'(QUEUE_DEPTH);
        if (fetchReq && !fetchDone)
          dropPending <= 1'b1;
      end
      else
      begin
        credits <= creditsNext;
        if (deliver)
          pc <= fetchAddr + ADDR_W'(4);
        if (!fetchReq && credits != '0)
          fetchReq <= 1'b1;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_in)
  begin
    if (rdy_in)
    begin
      if (!fetchReq)
        fetchAddr <= pc;
      if (deliver)
      begin
        instrWord <= fetchWord;
        instrPc   <= fetchAddr;
      end
    end
  end

  assert property (@(posedge clk_in) disable iff (rst_in)
    credits <= CNT_W'(QUEUE_DEPTH));

  // Each delivered word spends a credit that was really held
  assert property (@(posedge clk_in) disable iff (rst_in)
    deliver |-> credits != '0);

endmodule

//--- logic/execUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// In-order, one entry per cycle. Loads are LBU only and stores SB only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module execUnit (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         rdy_in,
  input  logic                         instrValid,
  input  logic [isaPkg::XLEN-1:0]      instrWord,
  input  logic [memMapPkg::ADDR_W-1:0] instrPc,
  input  logic                         dataDone,
  input  logic [7:0]                   dataRdata,
  output logic                         instrCredit,
  output logic                         redirectValid,
  output logic [memMapPkg::ADDR_W-1:0] redirectPc,
  output logic                         dataReq,
  output memMapPkg::memAccessT         dataKind,
  output logic [memMapPkg::ADDR_W-1:0] dataAddr,
  output logic [7:0]                   dataWdata,
  output logic [isaPkg::XLEN-1:0]      dbgReg
);
  import isaPkg::*;
  import memMapPkg::*;

  logic [XLEN-1:0]        qWord [QUEUE_DEPTH];
  logic [ADDR_W-1:0]      qPc [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] qHead;
  logic [QUEUE_PTR_W-1:0] qTail;
  logic [CNT_W-1:0]       qCount;
  logic                   halted;
  logic [XLEN-1:0]        regs [2**REG_ADDR_W];

  logic [XLEN-1:0]       word;
  logic [ADDR_W-1:0]     pc;
  opcodeT                opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [XLEN-1:0]       rs1Val;
  logic [XLEN-1:0]       rs2Val;
  logic [XLEN-1:0]       immI;
  logic [XLEN-1:0]       immS;
  logic [XLEN-1:0]       immB;
  logic [XLEN-1:0]       immU;
  logic [XLEN-1:0]       immJ;
  aluOpT                 aluOp;
  logic                  writeRd;
  logic                  isLoad;
  logic                  isStore;
  logic                  isBranch;
  logic                  isJal;
  logic [XLEN-1:0]       opA;
  logic [XLEN-1:0]       opB;
  logic [XLEN-1:0]       aluResult;
  logic [XLEN-1:0]       wbData;
  logic                  execEnable;
  logic                  branchTaken;
  logic                  advance;

  assign qTail  = qHead + QUEUE_PTR_W'(qCount);
  assign word   = qWord[qHead];
  assign pc     = qPc[qHead];
  assign opcode = opcodeT'(word[OPCODE_HI:OPCODE_LO]);
  assign funct3 = word[FUNCT3_HI:FUNCT3_LO];
  assign funct7 = word[FUNCT7_HI:FUNCT7_LO];
  assign rd     = word[RD_LO +: REG_ADDR_W];
  assign rs1    = word[RS1_LO +: REG_ADDR_W];
  assign rs2    = word[RS2_LO +: REG_ADDR_W];

  assign immI = {{20{word[31]}}, word[31:20]};
  assign immS = {{20{word[31]}}, word[31:25], word[11:7]};
  assign immB = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
  assign immU = {word[31:12], 12'b0};
  assign immJ = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

  // x0 is never written but reads as zero regardless
  assign rs1Val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2Val = (rs2 == '0) ? '0 : regs[rs2];
  assign dbgReg = regs[DBG_REG];

  always_comb
  begin
    aluOp    = aluAdd;
    writeRd  = 1'b0;
    isLoad   = 1'b0;
    isStore  = 1'b0;
    isBranch = 1'b0;
    isJal    = 1'b0;
    case (opcode)
      opcLui:
        writeRd = 1'b1;
      opcOpImm, opcOp:
      begin
        writeRd = 1'b1;
        case (funct3)
          3'b000:  aluOp = (opcode == opcOp && funct7[5]) ? aluSub : aluAdd;
          3'b100:  aluOp = aluXor;
          3'b110:  aluOp = aluOr;
          3'b111:  aluOp = aluAnd;
          default: writeRd = 1'b0;
        endcase
        // funct7 must be zero except for SUB
        if (opcode == opcOp && funct7 != 7'b0 &&
            !(funct7 == 7'b0100000 && funct3 == 3'b000))
          writeRd = 1'b0;
      end
      opcLoad:
      begin
        isLoad  = funct3 == 3'b100;
        writeRd = funct3 == 3'b100;
      end
      opcStore:
        isStore = funct3 == 3'b000;
      opcBranch:
        isBranch = funct3[2:1] == 2'b00;
      opcJal:
      begin
        isJal   = 1'b1;
        writeRd = 1'b1;
      end
      default:
        writeRd = 1'b0;
    endcase
  end

  assign opA = (opcode == opcLui) ? '0 : rs1Val;
  assign opB = (opcode == opcOp) ? rs2Val : ((opcode == opcLui) ? immU : immI);

  always_comb
  begin
    case (aluOp)
      aluSub:  aluResult = opA - opB;
      aluAnd:  aluResult = opA & opB;
      aluOr:   aluResult = opA | opB;
      aluXor:  aluResult = opA ^ opB;
      default: aluResult = opA + opB;
    endcase
  end

  // funct3 bit 0 selects BNE over BEQ
  assign branchTaken = isBranch && (funct3[0] ? (rs1Val != rs2Val) : (rs1Val == rs2Val));

  assign execEnable    = (qCount != '0) && !halted;
  assign redirectValid = execEnable && (isJal || branchTaken);
  assign redirectPc    = pc + (isJal ? immJ : immB);

  // Memory ops hold the head until the arbiter answers
  assign dataReq   = execEnable && (isLoad || isStore);
  assign dataKind  = isStore ? memWrite : memRead;
  assign dataAddr  = rs1Val + (isStore ? immS : immI);
  assign dataWdata = rs2Val[7:0];

  assign advance     = execEnable && (!dataReq || dataDone);
  assign instrCredit = advance;

  assign wbData = isLoad ? {{(XLEN-8){1'b0}}, dataRdata} :
                  (isJal ? pc + ADDR_W'(4) : aluResult);

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      qHead  <= '0;
      qCount <= '0;
      halted <= 1'b0;
    end
    else if (rdy_in)
    begin
      if (redirectValid)
      begin
        // Entries behind a taken jump are on the wrong path
        qHead  <= '0;
        qCount <= '0;
      end
      else
      begin
        qHead  <= qHead + QUEUE_PTR_W'(advance);
        qCount <= qCount + CNT_W'(instrValid) - CNT_W'(advance);
      end
      if (advance && isStore && dataAddr == IO_HALT_ADDR)
        halted <= 1'b1;
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rdy_in && instrValid && !redirectValid)
    begin
      qWord[qTail] <= instrWord;
      qPc[qTail]   <= instrPc;
    end
  end

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      for (int i = 0; i < 2**REG_ADDR_W; i++)
        regs[i] <= '0;
    end
    else if (rdy_in && advance && writeRd && rd != '0)
      regs[rd] <= wbData;
  end

  // Credit flow from fetchUnit must keep the queue from overflowing
  assert property (@(posedge clk_in) disable iff (rst_in)
    instrValid |-> qCount < CNT_W'(QUEUE_DEPTH));

endmodule

//--- logic/cpu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Whole core freezes while rdy_in is low. dbgreg_dout shows x10
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cpu (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         rdy_in,
  input  logic [7:0]                   mem_din,
  output logic [7:0]                   mem_dout,
  output logic [memMapPkg::ADDR_W-1:0] mem_a,
  output logic                         mem_wr,
  input  logic                         io_buffer_full,
  output logic [isaPkg::XLEN-1:0]      dbgreg_dout
);
  import isaPkg::*;
  import memMapPkg::*;

  // Fetch port
  logic              fetchReq;
  logic [ADDR_W-1:0] fetchAddr;
  logic              fetchDone;
  logic [XLEN-1:0]   fetchWord;

  // Instruction link
  logic              instrValid;
  logic [XLEN-1:0]   instrWord;
  logic [ADDR_W-1:0] instrPc;
  logic              instrCredit;
  logic              redirectValid;
  logic [ADDR_W-1:0] redirectPc;

  // Data port
  logic              dataReq;
  memAccessT         dataKind;
  logic [ADDR_W-1:0] dataAddr;
  logic [7:0]        dataWdata;
  logic              dataDone;
  logic [7:0]        dataRdata;

  fetchUnit fetch (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .rdy_in        (rdy_in),
    .fetchDone     (fetchDone),
    .fetchWord     (fetchWord),
    .instrCredit   (instrCredit),
    .redirectValid (redirectValid),
    .redirectPc    (redirectPc),
    .fetchReq      (fetchReq),
    .fetchAddr     (fetchAddr),
    .instrValid    (instrValid),
    .instrWord     (instrWord),
    .instrPc       (instrPc)
  );

  execUnit exec (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .rdy_in        (rdy_in),
    .instrValid    (instrValid),
    .instrWord     (instrWord),
    .instrPc       (instrPc),
    .dataDone      (dataDone),
    .dataRdata     (dataRdata),
    .instrCredit   (instrCredit),
    .redirectValid (redirectValid),
    .redirectPc    (redirectPc),
    .dataReq       (dataReq),
    .dataKind      (dataKind),
    .dataAddr      (dataAddr),
    .dataWdata     (dataWdata),
    .dbgReg        (dbgreg_dout)
  );

  memArbiter arbiter (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .memDin       (mem_din),
    .ioBufferFull (io_buffer_full),
    .fetchReq     (fetchReq),
    .fetchAddr    (fetchAddr),
    .dataReq      (dataReq),
    .dataKind     (dataKind),
    .dataAddr     (dataAddr),
    .dataWdata    (dataWdata),
    .memDout      (mem_dout),
    .memA         (mem_a),
    .memWr        (mem_wr),
    .fetchDone    (fetchDone),
    .fetchWord    (fetchWord),
    .dataDone     (dataDone),
    .dataRdata    (dataRdata)
  );

endmodule

//--- dv/tbMemory.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 128 KB byte RAM, read data one cycle after the address
// Writes at or above 0x20000 are ignored here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tbMemory (
  input  logic        clk_in,
  input  logic [31:0] addr,
  input  logic        wr,
  input  logic [7:0]  din,
  output logic [7:0]  dout = 8'h00
);
  localparam int RAM_BYTES = 32'h2_0000;

  logic [7:0] mem [RAM_BYTES];

  always @(posedge clk_in)
  begin
    if (wr && addr < RAM_BYTES)
      mem[addr[16:0]] <= din;
    dout <= mem[addr[16:0]];
  end

  // Background pattern folds every address bit into the byte
  task automatic fillPattern();
    logic [16:0] a;
    for (int i = 0; i < RAM_BYTES; i++)
    begin
      a = i[16:0];
      mem[i] = a[7:0] ^ a[15:8] ^ {7'b0, a[16]};
    end
  endtask

  // Little-endian word store for program loading
  task automatic writeWord(input int byteAddr, input logic [31:0] word);
    for (int b = 0; b < 4; b++)
      mem[byteAddr + b] = word[8*b +: 8];
  endtask

endmodule

//--- dv/cpuTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Runs one fixed program with random stalls and UART back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cpuTb;
  import isaPkg::*;
  import memMapPkg::*;

  localparam int N_EXPECTED  = 10;
  localparam int MAX_CYCLES  = 20000;
  localparam int HALT_WINDOW = 200;

  logic              clk_in = 1'b0;
  logic              rst_in = 1'b1;
  logic              rdy_in = 1'b1;
  logic              io_buffer_full = 1'b0;
  logic [7:0]        mem_din;
  logic [7:0]        mem_dout;
  logic [ADDR_W-1:0] mem_a;
  logic              mem_wr;
  logic [XLEN-1:0]   dbgreg_dout;

  int         seed = 10259;
  int         errors = 0;
  int         timeouts = 0;
  int         uartIdx = 0;
  int         haltCount = 0;
  int         burstLeft = 0;
  logic       afterHalt = 1'b0;
  logic [7:0] expected [N_EXPECTED];
  logic       uartWrite;
  logic       haltWrite;

  cpu dut (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .mem_din        (mem_din),
    .mem_dout       (mem_dout),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr),
    .io_buffer_full (io_buffer_full),
    .dbgreg_dout    (dbgreg_dout)
  );

  tbMemory ram (
    .clk_in (clk_in),
    .addr   (mem_a),
    .wr     (mem_wr),
    .din    (mem_dout),
    .dout   (mem_din)
  );

  always #10 clk_in = ~clk_in;

  function automatic logic [31:0] encU(input int imm20, input int rd, input opcodeT opc);
    return {imm20[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] encI(input int imm, input int rs1, input int f3,
                                       input int rd, input opcodeT opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] encR(input int f7, input int rs2, input int rs1,
                                       input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opcOp};
  endfunction

  function automatic logic [31:0] encS(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:0], opcStore};
  endfunction

  function automatic logic [31:0] encB(input int off, input int rs2, input int rs1,
                                       input int f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], opcBranch};
  endfunction

  function automatic logic [31:0] encJ(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opcJal};
  endfunction

  task automatic loadProgram();
    logic [31:0] prog [33];
    prog[0]  = encU(32'h30, 5, opcLui);
    prog[1]  = encU(32'h12345, 6, opcLui);
    prog[2]  = encS(0, 6, 5);                 // Prints 0x00
    prog[3]  = encI(32'h5A, 0, 0, 7, opcOpImm);
    prog[4]  = encS(0, 7, 5);
    prog[5]  = encI(32'h33, 0, 0, 8, opcOpImm);
    prog[6]  = encR(0, 8, 7, 0, 9);
    prog[7]  = encS(0, 9, 5);
    prog[8]  = encR(32'h20, 8, 7, 0, 9);
    prog[9]  = encS(0, 9, 5);
    prog[10] = encR(0, 8, 7, 7, 9);
    prog[11] = encS(0, 9, 5);
    prog[12] = encR(0, 8, 7, 6, 9);
    prog[13] = encS(0, 9, 5);
    prog[14] = encR(0, 8, 7, 4, 9);
    prog[15] = encS(0, 9, 5);
    // RAM round trip through address 0x403
    prog[16] = encI(32'h400, 0, 0, 11, opcOpImm);
    prog[17] = encI(32'h7C5, 0, 0, 12, opcOpImm);
    prog[18] = encS(3, 12, 11);
    prog[19] = encI(3, 11, 4, 10, opcLoad);
    prog[20] = encS(0, 10, 5);
    prog[21] = encB(8, 7, 7, 1);               // BNE, not taken
    prog[22] = encI(32'h41, 0, 0, 13, opcOpImm);
    prog[23] = encS(0, 13, 5);
    prog[24] = encB(12, 7, 7, 0);              // BEQ over a marker
    prog[25] = encI(32'hEE, 0, 0, 13, opcOpImm);
    prog[26] = encS(0, 13, 5);
    prog[27] = encJ(12, 1);                    // x1 gets 112
    prog[28] = encI(32'hEE, 0, 0, 13, opcOpImm);
    prog[29] = encS(0, 13, 5);
    prog[30] = encS(0, 1, 5);
    prog[31] = encS(4, 0, 5);                  // Halt store
    prog[32] = encJ(0, 0);
    for (int i = 0; i < 33; i++)
      ram.writeWord(4 * i, prog[i]);
    expected = '{8'h00, 8'h5A, 8'h8D, 8'h27, 8'h12, 8'h7B, 8'h69, 8'hC5, 8'h41, 8'h70};
  endtask

  // Stall and back-pressure, one random stream
  always @(posedge clk_in)
  begin
    if (!rst_in)
    begin
      #2;
      rdy_in <= ($unsigned($random(seed)) % 5) != 0;
      if (burstLeft > 0)
      begin
        io_buffer_full <= 1'b1;
        burstLeft <= burstLeft - 1;
      end
      else
      begin
        io_buffer_full <= 1'b0;
        if (($unsigned($random(seed)) % 10) == 0)
          burstLeft <= 1 + int'($unsigned($random(seed)) % 8);
      end
    end
  end

  // A bus write is consumed at the edge where rdy_in is high
  assign uartWrite = mem_wr && rdy_in && mem_a == IO_UART_ADDR;
  assign haltWrite = mem_wr && rdy_in && mem_a == IO_HALT_ADDR;

  always @(posedge clk_in)
  begin
    if (!rst_in)
    begin
      if (uartWrite)
        uartIdx <= uartIdx + 1;
      if (haltWrite)
      begin
        haltCount <= haltCount + 1;
        afterHalt <= 1'b1;
      end
    end
  end

  uartByteCheck: assert property (@(posedge clk_in) disable iff (rst_in)
    uartWrite |-> (uartIdx < N_EXPECTED) && mem_dout == expected[uartIdx])
  else
  begin
    errors++;
    $display("Fail at %0t: UART byte %0d is 0x%02h, not the expected one", $time, uartIdx,
             mem_dout);
  end

  pauseCheck: assert property (@(posedge clk_in) disable iff (rst_in)
    !rdy_in |=> $stable(mem_a) && $stable(mem_dout) && $stable(mem_wr))
  else
  begin
    errors++;
    $display("Fail at %0t: bus outputs changed while rdy_in was low", $time);
  end

  // A UART write may only start at an edge where the buffer had room
  backPressureCheck: assert property (@(posedge clk_in) disable iff (rst_in)
    (mem_wr && !$past(mem_wr) && mem_a == IO_UART_ADDR) |-> !$past(io_buffer_full))
  else
  begin
    errors++;
    $display("Fail at %0t: UART write started while io_buffer_full was high", $time);
  end

  haltQuietCheck: assert property (@(posedge clk_in) disable iff (rst_in)
    afterHalt |-> !mem_wr)
  else
  begin
    errors++;
    $display("Fail at %0t: mem_wr after the halt store, address 0x%05h", $time, mem_a);
  end

  initial
  begin
    ram.fillPattern();
    loadProgram();
    repeat (5) @(posedge clk_in);
    #2;
    rst_in = 1'b0;
    for (int cyc = 0; cyc < MAX_CYCLES && haltCount == 0; cyc++)
      @(posedge clk_in);
    if (haltCount == 0)
    begin
      timeouts++;
      $display("The halt store was not reached within %0d cycles", MAX_CYCLES);
    end
    else
    begin
      // Watch the bus for a while after halt
      for (int cyc = 0; cyc < HALT_WINDOW; cyc++)
        @(posedge clk_in);
      #1;
      assert (uartIdx == N_EXPECTED && haltCount == 1)
      else
      begin
        errors++;
        $display("Fail at %0t: %0d UART bytes and %0d halt stores seen", $time, uartIdx,
                 haltCount);
      end
      assert (dbgreg_dout == 32'h0000_00C5)
      else
      begin
        errors++;
        $display("Fail at %0t: dbgreg_dout is 0x%08h, x10 should be 0xC5", $time,
                 dbgreg_dout);
      end
    end
    $display("Errors: %0d, timeouts: %0d, UART bytes: %0d of %0d", errors, timeouts,
             uartIdx, N_EXPECTED);
    if (errors == 0 && timeouts == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- all.f
logic/isaPkg.sv
logic/memMapPkg.sv
logic/memArbiter.sv
logic/fetchUnit.sv
logic/execUnit.sv
logic/cpu.sv
dv/tbMemory.sv
dv/cpuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpuTb -Mdir build -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./build/VcpuTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" sim.log; then
  exit 1
fi
exit 0
